// File: alu_settings.svh
/* queue depth, credit and tag width macros
   shared by every block of the ALU execution unit */
`ifndef ALU_SETTINGS_SVH
`define ALU_SETTINGS_SVH

// command queue entries, also the credits the upstream starts with
`define ALU_INGRESS_DEPTH 4

// result queue entries, also the internal credits held by the ingress
`define ALU_EGRESS_DEPTH 4

// downstream buffer size, credits the egress starts with
`define ALU_OUT_CREDITS 2

// width of the tag that follows a command to its result
`define ALU_TAG_WIDTH 4

`endif

// File: aluOpPkg.sv
/* command-side types: opcode enum and command struct */
`default_nettype none

`include "alu_settings.svh"

package aluOpPkg;

    // 6502 style operations
    typedef enum logic [2:0] {
        // add with carry, BCD capable
        ADC = 3'd0,
        // subtract with borrow, BCD capable
        SBC = 3'd1,
        AND = 3'd2,
        EOR = 3'd3,
        ORA = 3'd4,
        // shifts work on operand a only
        ASL = 3'd5,
        LSR = 3'd6,
        ROR = 3'd7
    } aluOpT;

    // one command as it enters the unit
    typedef struct packed {
        aluOpT                     op;
        logic [7:0]                a;
        logic [7:0]                b;
        // also the bit rotated in by ROR
        logic                      carryIn;
        // only honoured for ADC and SBC
        logic                      decimal;
        logic [`ALU_TAG_WIDTH-1:0] tag;
    } aluCmdT;

endpackage

`default_nettype wire

// File: aluFlowPkg.sv
/* result-side types: flag struct, result struct
   and the stage struct between binary ALU and decimal adjust */
`default_nettype none

`include "alu_settings.svh"

package aluFlowPkg;

    // status flags produced per result
    typedef struct packed {
        logic n;
        logic v;
        logic z;
        logic c;
    } aluFlagsT;

    // one result as it leaves the unit
    typedef struct packed {
        logic [7:0]                value;
        aluFlagsT                  flags;
        logic [`ALU_TAG_WIDTH-1:0] tag;
    } aluResultT;

    // binary ALU output, registered before decimal correction
    typedef struct packed {
        logic                      valid;
        aluOpPkg::aluOpT           op;
        logic                      decimal;
        logic [7:0]                sum;
        logic                      halfCarry;
        logic                      carry;
        logic                      overflow;
        logic [`ALU_TAG_WIDTH-1:0] tag;
    } aluStageT;

endpackage

`default_nettype wire

// File: cmdIngress.sv
/* command queue with upstream credit return and
   issue into the pipeline gated by internal credits */
`default_nettype none

`include "alu_settings.svh"

module cmdIngress (
    input  wire                 phi2,
    input  wire                 arstN,
    input  wire                 cmdValid,
    input  wire aluOpPkg::aluCmdT cmd,
    input  wire                 slotFree,
    output logic                cmdCredit,
    output logic                issueValid,
    output aluOpPkg::aluCmdT    issueCmd
);
    import aluOpPkg::*;

    localparam int PtrW = $clog2(`ALU_INGRESS_DEPTH);
    localparam int CntW = $clog2(`ALU_INGRESS_DEPTH + 1);
    localparam int CrdW = $clog2(`ALU_EGRESS_DEPTH + 1);

    aluCmdT          queueMem [`ALU_INGRESS_DEPTH];
    logic [PtrW-1:0] wrPtr;
    logic [PtrW-1:0] rdPtr;
    logic [CntW-1:0] count;
    logic [CrdW-1:0] credits;
    logic            pop;

    function automatic logic [PtrW-1:0] nextPtr(input logic [PtrW-1:0] ptr);
        return (ptr == PtrW'(`ALU_INGRESS_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // an entry may only leave once a result slot is reserved for it
    assign pop        = (count != '0) && (credits != '0);
    assign issueValid = pop;
    assign issueCmd   = queueMem[rdPtr];
    // the freed entry goes straight back to the upstream
    assign cmdCredit  = pop;

    always_ff @(posedge phi2 or negedge arstN) begin
        if (!arstN) begin
            wrPtr   <= '0;
            rdPtr   <= '0;
            count   <= '0;
            credits <= CrdW'(`ALU_EGRESS_DEPTH);
        end else begin
            if (cmdValid) begin
                wrPtr <= nextPtr(wrPtr);
            end
            if (pop) begin
                rdPtr <= nextPtr(rdPtr);
            end
            count   <= count + CntW'(cmdValid) - CntW'(pop);
            credits <= credits + CrdW'(slotFree) - CrdW'(pop);
        end
    end

    always_ff @(posedge phi2) begin
        if (cmdValid) begin
            queueMem[wrPtr] <= cmd;
        end
    end

    // upstream credit discipline keeps the queue from overflowing
    assert property (@(posedge phi2) disable iff (!arstN)
        cmdValid |-> (count != CntW'(`ALU_INGRESS_DEPTH)))
        else $error("cmdIngress: command pushed into a full queue");

    // egress never frees more slots than were reserved
    assert property (@(posedge phi2) disable iff (!arstN)
        credits <= CrdW'(`ALU_EGRESS_DEPTH))
        else $error("cmdIngress: internal credit count above egress depth");

endmodule

`default_nettype wire

// File: aluCore.sv
/* binary ALU stage: add, subtract, logic and shift ops,
   registered together with half carry, carry and overflow */
`default_nettype none

module aluCore (
    input  wire                   phi2,
    input  wire                   arstN,
    input  wire                   issueValid,
    input  wire aluOpPkg::aluCmdT issueCmd,
    output aluFlowPkg::aluStageT  stage
);
    import aluOpPkg::*;
    import aluFlowPkg::*;

    aluStageT   nextStage;
    aluStageT   stageData;
    logic       stageValid;
    logic [7:0] bOp;
    logic [4:0] lowSum;
    logic [4:0] highSum;

    always_comb begin
        // SBC is a + ~b + carry, borrow is the inverted carry
        bOp     = (issueCmd.op == SBC) ? ~issueCmd.b : issueCmd.b;
        // two nibble steps so the half carry is visible
        lowSum  = {1'b0, issueCmd.a[3:0]} + {1'b0, bOp[3:0]} + 5'(issueCmd.carryIn);
        highSum = {1'b0, issueCmd.a[7:4]} + {1'b0, bOp[7:4]} + 5'(lowSum[4]);

        nextStage         = '0;
        nextStage.op      = issueCmd.op;
        nextStage.decimal = issueCmd.decimal;
        nextStage.tag     = issueCmd.tag;
        // logic ops keep the incoming carry
        nextStage.carry   = issueCmd.carryIn;

        unique case (issueCmd.op)
            ADC, SBC: begin
                nextStage.sum       = {highSum[3:0], lowSum[3:0]};
                nextStage.halfCarry = lowSum[4];
                nextStage.carry     = highSum[4];
                // same operand signs but a different sum sign
                nextStage.overflow  = (issueCmd.a[7] == bOp[7]) &&
                                      (highSum[3] != issueCmd.a[7]);
            end
            AND: begin
                nextStage.sum = issueCmd.a & issueCmd.b;
            end
            EOR: begin
                nextStage.sum = issueCmd.a ^ issueCmd.b;
            end
            ORA: begin
                nextStage.sum = issueCmd.a | issueCmd.b;
            end
            ASL: begin
                nextStage.sum   = {issueCmd.a[6:0], 1'b0};
                nextStage.carry = issueCmd.a[7];
            end
            LSR: begin
                nextStage.sum   = {1'b0, issueCmd.a[7:1]};
                nextStage.carry = issueCmd.a[0];
            end
            ROR: begin
                nextStage.sum   = {issueCmd.carryIn, issueCmd.a[7:1]};
                nextStage.carry = issueCmd.a[0];
            end
        endcase
    end

    always_ff @(posedge phi2 or negedge arstN) begin
        if (!arstN) begin
            stageValid <= 1'b0;
        end else begin
            stageValid <= issueValid;
        end
    end

    always_ff @(posedge phi2) begin
        if (issueValid) begin
            stageData <= nextStage;
        end
    end

    always_comb begin
        stage       = stageData;
        stage.valid = stageValid;
    end

endmodule

`default_nettype wire

// File: decimalAdjust.sv
/* decimal adjust stage: BCD correction for ADC and SBC,
   final flag assembly and the result register */
`default_nettype none

module decimalAdjust (
    input  wire                       phi2,
    input  wire                       arstN,
    input  wire aluFlowPkg::aluStageT stage,
    output logic                      resultValid,
    output aluFlowPkg::aluResultT     result
);
    import aluOpPkg::*;
    import aluFlowPkg::*;

    aluResultT  nextResult;
    logic       bcdMode;
    logic       lowAdj;
    logic       highAdj;
    logic       carryOut;
    logic [8:0] midSum;
    logic [7:0] corr;

    always_comb begin
        bcdMode  = stage.decimal && ((stage.op == ADC) || (stage.op == SBC));
        lowAdj   = 1'b0;
        highAdj  = 1'b0;
        carryOut = stage.carry;
        midSum   = {1'b0, stage.sum};

        if (bcdMode && (stage.op == ADC)) begin
            lowAdj   = (stage.sum[3:0] > 4'd9) || stage.halfCarry;
            midSum   = {1'b0, stage.sum} + (lowAdj ? 9'h006 : 9'h000);
            highAdj  = stage.carry || (midSum > 9'h099);
            carryOut = highAdj;
        end else if (bcdMode) begin
            // subtract: a borrow out of a nibble needs the 6 taken off
            lowAdj  = !stage.halfCarry;
            highAdj = !stage.carry;
        end

        // 0x06 and 0x60 correction terms
        corr = {1'b0, highAdj, highAdj, 1'b0, 1'b0, lowAdj, lowAdj, 1'b0};

        nextResult.value   = (stage.op == SBC) ? stage.sum - corr : stage.sum + corr;
        // N, V and Z follow the binary result even in decimal mode
        nextResult.flags.n = stage.sum[7];
        nextResult.flags.v = stage.overflow;
        nextResult.flags.z = (stage.sum == 8'h00);
        nextResult.flags.c = carryOut;
        nextResult.tag     = stage.tag;
    end

    always_ff @(posedge phi2 or negedge arstN) begin
        if (!arstN) begin
            resultValid <= 1'b0;
        end else begin
            resultValid <= stage.valid;
        end
    end

    always_ff @(posedge phi2) begin
        if (stage.valid) begin
            result <= nextResult;
        end
    end

    // a logic or shift op leaves its sum untouched in the registered result
    assert property (@(posedge phi2) disable iff (!arstN)
        (stage.valid && !(stage.op inside {ADC, SBC})) |=>
            (result.value == $past(stage.sum)))
        else $error("decimalAdjust: BCD correction on a logic or shift op");

endmodule

`default_nettype wire

// File: resultEgress.sv
/* result queue with downstream credit counter and
   internal slot release back to the ingress */
`default_nettype none

`include "alu_settings.svh"

module resultEgress (
    input  wire                        phi2,
    input  wire                        arstN,
    input  wire                        resultValid,
    input  wire aluFlowPkg::aluResultT result,
    input  wire                        resCredit,
    output logic                       resValid,
    output aluFlowPkg::aluResultT      res,
    output logic                       slotFree
);
    import aluFlowPkg::*;

    localparam int PtrW = $clog2(`ALU_EGRESS_DEPTH);
    localparam int CntW = $clog2(`ALU_EGRESS_DEPTH + 1);
    localparam int OutW = $clog2(`ALU_OUT_CREDITS + 1);

    aluResultT       queueMem [`ALU_EGRESS_DEPTH];
    logic [PtrW-1:0] wrPtr;
    logic [PtrW-1:0] rdPtr;
    logic [CntW-1:0] count;
    logic [OutW-1:0] outCredits;

    function automatic logic [PtrW-1:0] nextPtr(input logic [PtrW-1:0] ptr);
        return (ptr == PtrW'(`ALU_EGRESS_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // head entry goes out whenever the downstream has room
    assign resValid = (count != '0) && (outCredits != '0);
    assign res      = queueMem[rdPtr];
    // each delivery frees a slot the ingress may reserve again
    assign slotFree = resValid;

    always_ff @(posedge phi2 or negedge arstN) begin
        if (!arstN) begin
            wrPtr      <= '0;
            rdPtr      <= '0;
            count      <= '0;
            outCredits <= OutW'(`ALU_OUT_CREDITS);
        end else begin
            if (resultValid) begin
                wrPtr <= nextPtr(wrPtr);
            end
            if (resValid) begin
                rdPtr <= nextPtr(rdPtr);
            end
            count      <= count + CntW'(resultValid) - CntW'(resValid);
            outCredits <= outCredits + OutW'(resCredit) - OutW'(resValid);
        end
    end

    always_ff @(posedge phi2) begin
        if (resultValid) begin
            queueMem[wrPtr] <= result;
        end
    end

    // slots reserved at issue guarantee room for every item in flight
    assert property (@(posedge phi2) disable iff (!arstN)
        resultValid |-> (count != CntW'(`ALU_EGRESS_DEPTH)))
        else $error("resultEgress: result written into a full queue");

    // the downstream never hands back more credits than it was granted
    assert property (@(posedge phi2) disable iff (!arstN)
        outCredits <= OutW'(`ALU_OUT_CREDITS))
        else $error("resultEgress: downstream credit count above buffer size");

endmodule

`default_nettype wire

// File: aluUnit.sv
/* top level of the ALU execution unit: ingress queue,
   binary ALU, decimal adjust and egress queue */
`default_nettype none

module aluUnit (
    input  wire                   phi2,
    input  wire                   arstN,
    input  wire                   cmdValid,
    input  wire aluOpPkg::aluCmdT cmd,
    input  wire                   resCredit,
    output logic                  cmdCredit,
    output logic                  resValid,
    output aluFlowPkg::aluResultT res
);
    import aluOpPkg::*;
    import aluFlowPkg::*;

    logic      issueValid;
    aluCmdT    issueCmd;
    aluStageT  stage;
    logic      resultValid;
    aluResultT result;
    // egress slot released, credit back to the ingress
    logic      slotFree;

    cmdIngress ingress (
        .phi2       (phi2),
        .arstN      (arstN),
        .cmdValid   (cmdValid),
        .cmd        (cmd),
        .slotFree   (slotFree),
        .cmdCredit  (cmdCredit),
        .issueValid (issueValid),
        .issueCmd   (issueCmd)
    );

    aluCore core (
        .phi2       (phi2),
        .arstN      (arstN),
        .issueValid (issueValid),
        .issueCmd   (issueCmd),
        .stage      (stage)
    );

    decimalAdjust adjust (
        .phi2        (phi2),
        .arstN       (arstN),
        .stage       (stage),
        .resultValid (resultValid),
        .result      (result)
    );

    resultEgress egress (
        .phi2        (phi2),
        .arstN       (arstN),
        .resultValid (resultValid),
        .result      (result),
        .resCredit   (resCredit),
        .resValid    (resValid),
        .res         (res),
        .slotFree    (slotFree)
    );

endmodule

`default_nettype wire

// File: aluUnitTb.sv
/* testbench for the ALU execution unit: LCG stimulus, reference model,
   credit-based command source and result sink, checks and timeout */
`default_nettype none

`include "alu_settings.svh"

module aluUnitTb;
    timeunit 1ns;
    timeprecision 100ps;

    import aluOpPkg::*;
    import aluFlowPkg::*;

    localparam int NumCmds    = 400;
    localparam int CycleLimit = NumCmds * 16 + 500;

    logic      phi2;
    logic      arstN;
    logic      cmdValid;
    aluCmdT    cmd;
    logic      resCredit;
    logic      cmdCredit;
    logic      resValid;
    aluResultT res;

    // expected results and the commands behind them, in issue order
    aluResultT expQ[$];
    aluCmdT    sentQ[$];

    int upCredits  = `ALU_INGRESS_DEPTH;
    // credits the DUT holds towards the sink
    int outCredits = `ALU_OUT_CREDITS;
    // results sitting in the sink buffer, credit not yet returned
    int heldByTb   = 0;
    int sent       = 0;
    int received   = 0;
    int cycles     = 0;

    aluUnit UUT (
        .phi2      (phi2),
        .arstN     (arstN),
        .cmdValid  (cmdValid),
        .cmd       (cmd),
        .resCredit (resCredit),
        .cmdCredit (cmdCredit),
        .resValid  (resValid),
        .res       (res)
    );

    initial begin
        phi2 = 1'b0;
        forever #4 phi2 = ~phi2;
    end

    initial begin
        arstN = 1'b0;
        repeat (16) @(posedge phi2);
        #1 arstN = 1'b1;
    end

    function automatic logic [31:0] lcgStep(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic checkEq(input logic [31:0] got, input logic [31:0] want, input string what);
        if (got !== want) begin
            $display("ERROR at %0t ns: %s is %0h, expected %0h", $time, what, got, want);
            $display("Something failed");
            $fatal(1, "first mismatch reached");
        end
    endtask

    task automatic stopRun(input string why);
        $display("%s at %0t ns", why, $time);
        $display("Something failed");
        $fatal(1, "%s", why);
    endtask

    // expected result built from the opcode and decimal rules
    function automatic aluResultT modelResult(input aluCmdT c);
        aluResultT  r;
        logic [7:0] bIn;
        logic [7:0] bin;
        logic [8:0] full;
        logic [8:0] mid;
        logic       halfC;
        logic       lowFix;
        logic       highFix;
        bIn       = (c.op == SBC) ? ~c.b : c.b;
        full      = {1'b0, c.a} + {1'b0, bIn} + 9'(c.carryIn);
        halfC     = (5'(c.a[3:0]) + 5'(bIn[3:0]) + 5'(c.carryIn)) > 5'd15;
        r         = '0;
        r.tag     = c.tag;
        r.flags.c = c.carryIn;
        case (c.op)
            ADC, SBC: begin
                bin       = full[7:0];
                r.flags.c = full[8];
                r.flags.v = (c.a[7] == bIn[7]) && (bin[7] != c.a[7]);
            end
            AND: bin = c.a & c.b;
            EOR: bin = c.a ^ c.b;
            ORA: bin = c.a | c.b;
            ASL: begin
                bin       = {c.a[6:0], 1'b0};
                r.flags.c = c.a[7];
            end
            LSR: begin
                bin       = {1'b0, c.a[7:1]};
                r.flags.c = c.a[0];
            end
            ROR: begin
                bin       = {c.carryIn, c.a[7:1]};
                r.flags.c = c.a[0];
            end
        endcase
        r.value   = bin;
        r.flags.n = bin[7];
        r.flags.z = (bin == 8'h00);
        if (c.decimal && (c.op == ADC)) begin
            lowFix    = (bin[3:0] > 4'd9) || halfC;
            mid       = {1'b0, bin} + (lowFix ? 9'h006 : 9'h000);
            highFix   = full[8] || (mid > 9'h099);
            r.value   = mid[7:0] + (highFix ? 8'h60 : 8'h00);
            r.flags.c = highFix;
        end else if (c.decimal && (c.op == SBC)) begin
            r.value = bin - (halfC ? 8'h00 : 8'h06) - (full[8] ? 8'h00 : 8'h60);
        end
        return r;
    endfunction

    // plain decimal arithmetic, carry in bit 8 and two BCD digits below
    function automatic logic [8:0] bcdReference(input aluCmdT c);
        int   da;
        int   db;
        int   total;
        logic carry;
        da = int'(c.a[7:4]) * 10 + int'(c.a[3:0]);
        db = int'(c.b[7:4]) * 10 + int'(c.b[3:0]);
        if (c.op == ADC) begin
            total = da + db + int'(c.carryIn);
            carry = (total >= 100);
        end else begin
            // carry clear means a borrow is pending
            total = da - db - (c.carryIn ? 0 : 1);
            carry = (total >= 0);
        end
        if (total >= 100) total -= 100;
        if (total < 0) total += 100;
        return {carry, 4'(total / 10), 4'(total % 10)};
    endfunction

    task automatic makeCmd(inout logic [31:0] rng, input int tagNum, output aluCmdT c);
        rng       = lcgStep(rng);
        c.op      = aluOpT'(rng[18:16]);
        c.carryIn = rng[21];
        c.decimal = rng[25];
        c.tag     = tagNum[`ALU_TAG_WIDTH-1:0];
        rng       = lcgStep(rng);
        if (c.decimal && (c.op inside {ADC, SBC})) begin
            // valid BCD digits only
            c.a = {4'(rng[19:16] % 4'd10), 4'(rng[23:20] % 4'd10)};
            c.b = {4'(rng[27:24] % 4'd10), 4'(rng[31:28] % 4'd10)};
        end else begin
            c.a = rng[23:16];
            c.b = rng[31:24];
        end
    endtask

    initial begin : upstream
        logic [31:0] rng;
        aluCmdT      newCmd;
        rng      = 32'd69;
        cmdValid = 1'b0;
        cmd      = '0;
        wait (arstN === 1'b1);
        forever begin
            @(posedge phi2);
            #1;
            rng      = lcgStep(rng);
            cmdValid = 1'b0;
            if ((upCredits > 0) && (sent < NumCmds) && rng[20]) begin
                makeCmd(rng, sent, newCmd);
                cmd      = newCmd;
                cmdValid = 1'b1;
                upCredits--;
                sent++;
                expQ.push_back(modelResult(newCmd));
                sentQ.push_back(newCmd);
            end
            @(negedge phi2);
            if (cmdCredit) begin
                upCredits++;
            end
            if (upCredits > `ALU_INGRESS_DEPTH) begin
                stopRun("upstream got back more credits than the command queue holds");
            end
        end
    end

    initial begin : sink
        logic [31:0] rng;
        int          holdLeft;
        aluResultT   want;
        aluCmdT      src;
        logic [8:0]  bcd;
        rng       = 32'd69 ^ 32'h5A5A_0F0F;
        holdLeft  = 0;
        resCredit = 1'b0;
        wait (arstN === 1'b1);
        forever begin
            @(posedge phi2);
            // the DUT counts a returned credit at this edge
            if (resCredit) begin
                outCredits++;
            end
            #1;
            rng       = lcgStep(rng);
            resCredit = 1'b0;
            if (holdLeft > 0) begin
                holdLeft--;
            end else if (rng[20:16] == 5'd0) begin
                // long stretch with no credit back
                holdLeft = int'(rng[29:24]);
            end else if ((heldByTb > 0) && rng[22]) begin
                resCredit = 1'b1;
                heldByTb--;
            end
            @(negedge phi2);
            if (resValid) begin
                if (outCredits == 0) begin
                    stopRun("result delivered without a downstream credit");
                end
                if (expQ.size() == 0) begin
                    stopRun("result delivered with no command outstanding");
                end
                outCredits--;
                heldByTb++;
                received++;
                want = expQ.pop_front();
                src  = sentQ.pop_front();
                checkEq(res.tag, want.tag, "tag");
                checkEq(res.value, want.value, "value");
                checkEq(res.flags.n, want.flags.n, "flag N");
                checkEq(res.flags.v, want.flags.v, "flag V");
                checkEq(res.flags.z, want.flags.z, "flag Z");
                checkEq(res.flags.c, want.flags.c, "flag C");
                if (src.decimal && (src.op inside {ADC, SBC})) begin
                    bcd = bcdReference(src);
                    checkEq(res.value, bcd[7:0], "BCD value");
                    checkEq(res.flags.c, bcd[8], "BCD carry");
                end
            end
        end
    end

    initial begin : runEnd
        wait (arstN === 1'b1);
        while (received < NumCmds) begin
            @(negedge phi2);
            #2;
        end
        // sink hands back what it holds, then all counters settle
        while ((heldByTb > 0) || (outCredits != `ALU_OUT_CREDITS)) begin
            @(negedge phi2);
            #2;
        end
        repeat (4) @(negedge phi2);
        #2;
        checkEq(upCredits, `ALU_INGRESS_DEPTH, "upstream credits");
        if ((sent == NumCmds) && (expQ.size() == 0)) begin
            $display("Everything OK");
            $finish;
        end else begin
            $display("run ended with %0d results still expected", expQ.size());
            $display("Something failed");
            $fatal(1, "results left over");
        end
    end

    initial begin : watchdog
        while (cycles < CycleLimit) begin
            @(posedge phi2);
            cycles++;
        end
        stopRun("timeout: not all results arrived within the cycle limit");
    end

endmodule

`default_nettype wire

// File: src.f
+incdir+.
aluOpPkg.sv
aluFlowPkg.sv
cmdIngress.sv
aluCore.sv
decimalAdjust.sv
resultEgress.sv
aluUnit.sv
aluUnitTb.sv

// File: Bender.yml
package:
  name: alu_unit

export_include_dirs:
  - .

sources:
  - aluOpPkg.sv
  - aluFlowPkg.sv
  - cmdIngress.sv
  - aluCore.sv
  - decimalAdjust.sv
  - resultEgress.sv
  - aluUnit.sv
  - target: test
    files:
      - aluUnitTb.sv
